/* icache.f */
icache_pkg.sv
icache_sram.sv
icache_way.sv
icache_plru.sv
icache_ctrl.sv
icache.sv
icache_mem_model.sv
icache_tb.sv

/* icache_tb.sv */
module icache_tb
    import icache_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INDEX_W    = 8;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
    localparam int SETS       = 2 ** INDEX_W;
    localparam int NUM_REQ    = 400;
    localparam int CLK_PERIOD = 100;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              uncached;
        logic              hit;
        logic [31:0]       acc_cycle;
    } pending_t;

    logic                clk;
    logic                resetn;
    logic                valid;
    logic                uncache;
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
    logic                addr_ok;
    logic                data_ok;
    word_t               rdata;
    logic                rd_req;
    logic                rd_type;
    logic [ADDR_W-1:0]   rd_addr;
    logic                rd_rdy;
    logic                ret_valid;
    line_t               ret_data;

    // Reference cache
    logic                m_valid [SETS][NUM_WAYS];
    logic [TAG_W-1:0]    m_tag [SETS][NUM_WAYS];
    way_vec_t            m_mru [SETS];
    int                  m_victim;

    pending_t            pend_q [$];
    pending_t            head;
    logic                head_fetched;
    logic                req_taken;
    logic                run_en;
    logic                stalled;
    logic                last_type;
    logic [ADDR_W-1:0]   last_addr;
    logic [31:0]         cycle;
    int                  issued;
    int                  completed;

    icache #(
        .INDEX_W (INDEX_W)
    ) dut0 (.*);

    icache_mem_model mem0 (.*);

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // Returns the hit outcome and applies the access to the model
    function automatic logic model_access(input logic [TAG_W-1:0] t,
                                          input logic [INDEX_W-1:0] s);
        int   way;
        logic hit;
        logic found;
        hit   = 1'b0;
        found = 1'b0;
        way   = m_victim;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            // Victim is the first way not recently used
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (!found && !m_mru[s][w]) begin
                    found = 1'b1;
                    way   = w;
                end
            end
            m_victim        = way;
            m_valid[s][way] = 1'b1;
            m_tag[s][way]   = t;
        end
        // Marking the last unmarked way leaves only that way marked
        m_mru[s][way] = 1'b1;
        if (&m_mru[s]) begin
            m_mru[s]      = '0;
            m_mru[s][way] = 1'b1;
        end
        return hit;
    endfunction

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        void'($urandom(32'hbabb_bebb));
        clk          = 1'b0;
        resetn       = 1'b0;
        valid        = 1'b0;
        uncache      = 1'b0;
        tag          = '0;
        index        = '0;
        offset       = '0;
        run_en       = 1'b0;
        req_taken    = 1'b0;
        head_fetched = 1'b0;
        stalled      = 1'b0;
        cycle        = '0;
        issued       = 0;
        completed    = 0;
        m_victim     = 0;
        for (int s = 0; s < SETS; s++) begin
            m_mru[s] = '0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        run_en <= 1'b1;
        wait (completed == NUM_REQ);
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

    initial begin
        #(NUM_REQ * 20 * CLK_PERIOD);
        fail_run("timeout: the cache stopped completing requests");
    end

    // Few tags over few sets, so lines get evicted
    always @(posedge clk) begin
        if (run_en && (!valid || req_taken)) begin
            if (issued < NUM_REQ && $urandom_range(5, 0) != 0) begin
                valid   <= 1'b1;
                uncache <= ($urandom_range(7, 0) == 0);
                tag     <= TAG_W'(32'h100 + 32'h1f3 * $urandom_range(5, 0));
                index   <= INDEX_W'(32'h3 + 32'h5d * $urandom_range(2, 0));
                offset  <= OFFSET_W'($urandom);
                issued  <= issued + 1;
            end else begin
                valid <= 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (resetn) begin
            cycle++;
            if (rd_req) begin
                assert (pend_q.size() > 0 && !pend_q[0].hit && !head_fetched)
                else fail_run("memory read issued while no miss or uncached read was due");
                head = pend_q[0];
                assert (rd_type == !head.uncached && rd_addr == (head.uncached ? head.addr :
                        {head.addr[ADDR_W-1:OFFSET_W], OFFSET_W'(0)}))
                else fail_run($sformatf("mismatch at %0d ns: read type %0b addr %h for %h",
                                        $time, rd_type, rd_addr, head.addr));
                head_fetched = rd_rdy;
            end
            if (stalled) begin
                assert (rd_req && rd_type == last_type && rd_addr == last_addr)
                else fail_run($sformatf("mismatch at %0d ns: read request moved while stalled",
                                        $time));
            end
            stalled   = rd_req && !rd_rdy;
            last_type = rd_type;
            last_addr = rd_addr;
            if (pend_q.size() > 0) begin
                head = pend_q[0];
                if (head.hit && cycle == head.acc_cycle + 1) begin
                    assert (data_ok && addr_ok)
                    else fail_run($sformatf("mismatch at %0d ns: hit on %h not answered at once",
                                            $time, head.addr));
                end
                if (!head.hit) begin
                    assert (!addr_ok)
                    else fail_run("addr_ok raised while a memory read was still pending");
                end
            end
            if (data_ok) begin
                assert (pend_q.size() > 0)
                else fail_run("data_ok seen with no request outstanding");
                head = pend_q.pop_front();
                assert (head.hit || (head_fetched && ret_valid))
                else fail_run("miss or uncached read answered without a memory return");
                assert (rdata == mem_word_at(head.addr[ADDR_W-1:2]))
                else fail_run($sformatf("mismatch at %0d ns: rdata %h for %h, expected %h", $time,
                                        rdata, head.addr, mem_word_at(head.addr[ADDR_W-1:2])));
                head_fetched = 1'b0;
                completed++;
            end
            req_taken = valid && addr_ok;
            if (req_taken) begin
                head.addr      = {tag, index, offset};
                head.uncached  = uncache;
                head.hit       = uncache ? 1'b0 : model_access(tag, index);
                head.acc_cycle = cycle;
                pend_q.push_back(head);
            end
        end
    end

endmodule

/* icache_mem_model.sv */
// Memory contents at a word address, a multiply-and-xor scramble
function automatic logic [31:0] mem_word_at(input logic [29:0] word_addr);
    logic [31:0] a;
    a = {2'b00, word_addr};
    return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h6c8e_9cf5;
endfunction

module icache_mem_model
    import icache_pkg::*;
(
    input  logic              clk,
    input  logic              rd_req,
    input  logic              rd_type,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output line_t             ret_data
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [ADDR_W-1:0] req_addr;
    logic              req_line;
    int unsigned       stall;
    int unsigned       delay;

    function automatic line_t build_line(input logic line_fetch,
                                         input logic [ADDR_W-1:0] addr);
        line_t line;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            if (line_fetch) begin
                line[w] = mem_word_at({addr[ADDR_W-1:OFFSET_W], 2'(w)});
            end else begin
                // Word fetch carries data in word 0 only
                line[w] = (w == 0) ? mem_word_at(addr[ADDR_W-1:2]) : $urandom;
            end
        end
        return line;
    endfunction

    initial begin
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        forever begin
            @(negedge clk);
            if (rd_req) begin
                req_line = rd_type;
                req_addr = rd_addr;
                stall    = $urandom_range(3, 0);
                delay    = $urandom_range(5, 1);
                repeat (stall) @(posedge clk);
                @(posedge clk);
                rd_rdy <= 1'b1;
                // Handshake completes on this edge
                @(posedge clk);
                rd_rdy <= 1'b0;
                repeat (delay - 1) @(posedge clk);
                ret_valid <= 1'b1;
                ret_data  <= build_line(req_line, req_addr);
                @(posedge clk);
                ret_valid <= 1'b0;
                ret_data  <= '0;
            end
        end
    end

endmodule

/* icache.sv */
module icache
    import icache_pkg::*;
#(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                uncache,
    input  logic [TAG_W-1:0]    tag,
    input  logic [INDEX_W-1:0]  index,
    input  logic [OFFSET_W-1:0] offset,
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,
    output logic                rd_req,
    output logic                rd_type,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  line_t               ret_data
);

    logic               lookup_en;
    logic [INDEX_W-1:0] lookup_index;
    logic [TAG_W-1:0]   rb_tag;
    wire way_vec_t      way_hit;
    wire line_t         way_line [NUM_WAYS];
    way_sel_t           victim;
    way_vec_t           refill_we;
    logic [INDEX_W-1:0] refill_index;
    logic               hit_update;
    logic               fill_update;
    logic               miss_lookup;

    icache_ctrl #(
        .INDEX_W (INDEX_W)
    ) u_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .uncache      (uncache),
        .tag          (tag),
        .index        (index),
        .offset       (offset),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .rd_req       (rd_req),
        .rd_type      (rd_type),
        .rd_addr      (rd_addr),
        .rd_rdy       (rd_rdy),
        .ret_valid    (ret_valid),
        .ret_data     (ret_data),
        .lookup_en    (lookup_en),
        .lookup_index (lookup_index),
        .rb_tag       (rb_tag),
        .way_hit      (way_hit),
        .way_line     (way_line),
        .victim       (victim),
        .refill_we    (refill_we),
        .refill_index (refill_index),
        .hit_update   (hit_update),
        .fill_update  (fill_update),
        .miss_lookup  (miss_lookup)
    );

    // Set index is the buffered request, valid in LOOKUP and REPLACE
    icache_plru #(
        .INDEX_W (INDEX_W)
    ) u_plru (
        .clk         (clk),
        .resetn      (resetn),
        .hit_update  (hit_update),
        .fill_update (fill_update),
        .set_index   (refill_index),
        .hit_vec     (way_hit),
        .miss_lookup (miss_lookup),
        .victim      (victim)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : gen_way
        icache_way #(
            .INDEX_W (INDEX_W)
        ) u_way (
            .clk          (clk),
            .resetn       (resetn),
            .lookup_en    (lookup_en),
            .lookup_index (lookup_index),
            .cmp_tag      (rb_tag),
            .refill_we    (refill_we[g]),
            .refill_index (refill_index),
            .refill_line  (ret_data),
            .way_hit      (way_hit[g]),
            .way_line     (way_line[g])
        );
    end

endmodule

/* icache_ctrl.sv */
module icache_ctrl
    import icache_pkg::*;
#(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                valid,
    input  logic                uncache,
    input  logic [TAG_W-1:0]    tag,
    input  logic [INDEX_W-1:0]  index,
    input  logic [OFFSET_W-1:0] offset,
    output logic                addr_ok,
    output logic                data_ok,
    output word_t               rdata,
    output logic                rd_req,
    output logic                rd_type,
    output logic [ADDR_W-1:0]   rd_addr,
    input  logic                rd_rdy,
    input  logic                ret_valid,
    input  line_t               ret_data,
    output logic                lookup_en,
    output logic [INDEX_W-1:0]  lookup_index,
    output logic [TAG_W-1:0]    rb_tag,
    input  way_vec_t            way_hit,
    input  line_t               way_line [NUM_WAYS],
    input  way_sel_t            victim,
    output way_vec_t            refill_we,
    output logic [INDEX_W-1:0]  refill_index,
    output logic                hit_update,
    output logic                fill_update,
    output logic                miss_lookup
);

    localparam int WSEL_W = $clog2(WORDS_PER_LINE);

    ctrl_state_t         state;
    ctrl_state_t         next_state;
    logic [INDEX_W-1:0]  rb_index;
    logic [OFFSET_W-1:0] rb_offset;
    logic [WSEL_W-1:0]   word_sel;
    logic                accept;
    logic                cache_hit;
    word_t               hit_word;

    assign accept = valid && addr_ok;

    // Request buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            rb_tag    <= tag;
            rb_index  <= index;
            rb_offset <= offset;
        end
    end

    assign word_sel  = rb_offset[OFFSET_W-1 -: WSEL_W];
    assign cache_hit = |way_hit;

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_word |= way_line[w][word_sel];
            end
        end
    end

    // Ways and replacement
    assign lookup_en    = accept && !uncache;
    assign lookup_index = index;
    assign refill_index = rb_index;
    assign refill_we    = (state == REFILL && ret_valid) ? (way_vec_t'(1) << victim) : '0;
    assign hit_update   = (state == LOOKUP) && cache_hit;
    assign miss_lookup  = (state == LOOKUP) && !cache_hit;
    assign fill_update  = (state == REPLACE) && rd_rdy;

    // CPU side
    assign addr_ok = (state == IDLE) || ((state == LOOKUP) && cache_hit);
    assign data_ok = ((state == LOOKUP) && cache_hit) ||
                     ((state == REFILL) && ret_valid) ||
                     ((state == URESP) && ret_valid);

    always_comb begin
        case (state)
            LOOKUP:  rdata = hit_word;
            REFILL:  rdata = ret_data[word_sel];
            URESP:   rdata = ret_data[0];
            default: rdata = '0;
        endcase
    end

    // Memory side
    assign rd_req  = (state == REPLACE) || (state == UREQ);
    assign rd_type = (state != UREQ);
    assign rd_addr = (state == UREQ) ? {rb_tag, rb_index, rb_offset} :
                                       {rb_tag, rb_index, {OFFSET_W{1'b0}}};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end
            end
            LOOKUP: begin
                if (!cache_hit) begin
                    next_state = REPLACE;
                end else if (accept) begin
                    next_state = uncache ? UREQ : LOOKUP;
                end else begin
                    next_state = IDLE;
                end
            end
            REPLACE: begin
                if (rd_rdy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            UREQ: begin
                if (rd_rdy) begin
                    next_state = URESP;
                end
            end
            URESP: begin
                if (ret_valid) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

/* icache_plru.sv */
module icache_plru
    import icache_pkg::*;
#(
    parameter int INDEX_W = 8
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               hit_update,
    input  logic               fill_update,
    input  logic [INDEX_W-1:0] set_index,
    input  way_vec_t           hit_vec,
    input  logic               miss_lookup,
    output way_sel_t           victim
);

    localparam int SETS = 2 ** INDEX_W;

    way_vec_t mru [SETS];
    way_vec_t set_mru;
    way_vec_t touch_vec;
    way_vec_t next_mru;
    way_sel_t free_way;
    logic     free_found;

    assign set_mru = mru[set_index];

    always_comb begin
        touch_vec = '0;
        if (hit_update) begin
            touch_vec = hit_vec;
        end else if (fill_update) begin
            touch_vec[victim] = 1'b1;
        end
    end

    // A full set restarts with only the touched way marked
    assign next_mru = ((set_mru | touch_vec) == '1) ? touch_vec : (set_mru | touch_vec);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < SETS; s++) begin
                mru[s] <= '0;
            end
        end else if (hit_update || fill_update) begin
            mru[set_index] <= next_mru;
        end
    end

    // Lowest way not recently used
    always_comb begin
        free_found = 1'b0;
        free_way   = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!set_mru[w]) begin
                free_found = 1'b1;
                free_way   = way_sel_t'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim <= '0;
        end else if (miss_lookup && free_found) begin
            victim <= free_way;
        end
    end

endmodule

/* icache_way.sv */
module icache_way
    import icache_pkg::*;
#(
    parameter int INDEX_W = 8,
    localparam int TAG_W  = ADDR_W - INDEX_W - OFFSET_W
) (
    input  logic               clk,
    input  logic               resetn,
    input  logic               lookup_en,
    input  logic [INDEX_W-1:0] lookup_index,
    input  logic [TAG_W-1:0]   cmp_tag,
    input  logic               refill_we,
    input  logic [INDEX_W-1:0] refill_index,
    input  line_t              refill_line,
    output logic               way_hit,
    output line_t              way_line
);

    localparam int SETS = 2 ** INDEX_W;

    logic [SETS-1:0]    valid_bits;
    logic               valid_q;
    logic               ram_en;
    logic [INDEX_W-1:0] ram_addr;
    logic [TAG_W-1:0]   stored_tag;

    // Lookup and refill never overlap
    assign ram_en   = lookup_en | refill_we;
    assign ram_addr = lookup_en ? lookup_index : refill_index;

    icache_sram #(
        .word_type (logic [TAG_W-1:0]),
        .ADDR_BITS (INDEX_W)
    ) u_tag_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (refill_we),
        .addr (ram_addr),
        .din  (cmp_tag),
        .dout (stored_tag)
    );

    icache_sram #(
        .word_type (line_t),
        .ADDR_BITS (INDEX_W)
    ) u_line_ram (
        .clk  (clk),
        .en   (ram_en),
        .we   (refill_we),
        .addr (ram_addr),
        .din  (refill_line),
        .dout (way_line)
    );

    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
        end else if (refill_we) begin
            valid_bits[refill_index] <= 1'b1;
        end
    end

    // Same latency as the tag RAM read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_q <= 1'b0;
        end else if (lookup_en) begin
            valid_q <= valid_bits[lookup_index];
        end
    end

    assign way_hit = valid_q && (stored_tag == cmp_tag);

endmodule

/* icache_sram.sv */
module icache_sram #(
    parameter type word_type = logic [31:0],
    parameter int  ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 en,
    input  logic                 we,
    input  logic [ADDR_BITS-1:0] addr,
    input  word_type             din,
    output word_type             dout
);

    localparam int DEPTH = 2 ** ADDR_BITS;

    word_type mem [DEPTH];

    // Read-first, old contents appear on a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= din;
            end
            dout <= mem[addr];
        end
    end

endmodule

/* icache_pkg.sv */
package icache_pkg;

    // Address split
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;

    // Word and line geometry
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = LINE_W / WORD_W;

    // Fixed at four, the MRU replacement relies on it
    localparam int NUM_WAYS = 4;

    typedef logic [WORD_W-1:0] word_t;

    // Word 0 sits in the low bits, as on the memory return bus
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0] line_t;

    typedef logic [1:0] way_sel_t;

    typedef logic [NUM_WAYS-1:0] way_vec_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REPLACE,
        REFILL,
        UREQ,
        URESP
    } ctrl_state_t;

endpackage
